// File: Fp32Unit.sv
`timescale 1ns/1ns
`default_nettype none

module Fp32Unit import FpTypes::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  FpUnitType            unit,
    input  FpSignCommand         signCmd,
    input  FpCmpCommand          cmpCmd,
    input  logic [wordWidth-1:0] intSrc1,
    input  logic [wordWidth-1:0] fpSrc1,
    input  logic [wordWidth-1:0] fpSrc2,
    output logic                 outValid,
    output logic [wordWidth-1:0] intResult,
    output logic [wordWidth-1:0] fpResult,
    output logic                 nvPulse
);

    // ##################################################
    // Classifier.
    // ##################################################

    function automatic logic [wordWidth-1:0] classify(input logic [wordWidth-1:0] value);
        logic                 sign;
        logic                 expOnes;
        logic                 expZero;
        logic                 fracZero;
        logic [wordWidth-1:0] mask;
        sign     = value[wordWidth-1];
        expOnes  = &value[wordWidth-2 -: expWidth];
        expZero  = value[wordWidth-2 -: expWidth] == '0;
        fracZero = value[fracWidth-1:0] == '0;
        if (expOnes && !fracZero) begin
            mask = value[fracWidth-1] ? fpClassQuietNan : fpClassSignalingNan;
        end else if (expOnes) begin
            mask = sign ? fpClassNegInf : fpClassPosInf;
        end else if (expZero && fracZero) begin
            mask = sign ? fpClassNegZero : fpClassPosZero;
        end else if (expZero) begin
            mask = sign ? fpClassNegSubnormal : fpClassPosSubnormal;
        end else begin
            mask = sign ? fpClassNegNormal : fpClassPosNormal;
        end
        return mask;
    endfunction

    logic [wordWidth-1:0] classMask;

    assign classMask = classify(fpSrc1);

    // ##################################################
    // Sub-units and result select.
    // ##################################################

    logic [wordWidth-1:0] signResult;
    logic [wordWidth-1:0] cmpIntResult;
    logic [wordWidth-1:0] cmpFpResult;
    logic                 cmpInvalid;
    logic [wordWidth-1:0] selIntResult;
    logic [wordWidth-1:0] selFpResult;

    FpSignUnit signUnit (
        .fpResult(signResult),
        .command(signCmd),
        .fpSrc1(fpSrc1),
        .fpSrc2(fpSrc2)
    );

    FpComparator comparator (
        .intResult(cmpIntResult),
        .fpResult(cmpFpResult),
        .invalid(cmpInvalid),
        .command(cmpCmd),
        .fpSrc1(fpSrc1),
        .fpSrc2(fpSrc2)
    );

    always_comb begin
        case (unit)
            FpUnitMove: begin
                selIntResult = fpSrc1;   // fmv.x.w hands over the raw bits.
                selFpResult  = intSrc1;  // fmv.w.x likewise.
            end
            FpUnitClassifier: begin
                selIntResult = classMask;
                selFpResult  = '0;
            end
            FpUnitSign: begin
                selIntResult = '0;
                selFpResult  = signResult;
            end
            FpUnitComparator: begin
                selIntResult = cmpIntResult;
                selFpResult  = cmpFpResult;
            end
            default: begin
                selIntResult = '0;
                selFpResult  = '0;
            end
        endcase
    end

    // ##################################################
    // Output register.
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid  <= 1'b0;
            nvPulse   <= 1'b0;
            intResult <= '0;
            fpResult  <= '0;
        end else begin
            outValid <= inValid;
            nvPulse  <= inValid && (unit == FpUnitComparator) && cmpInvalid;
            if (inValid) begin
                intResult <= selIntResult;  // results hold until the next issue.
                fpResult  <= selFpResult;
            end
        end
    end

    // every result belongs to an issue one cycle earlier.
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> $past(inValid));

    assert property (@(posedge clk) disable iff (!rstN) nvPulse |-> outValid);

    assert property (@(posedge clk) disable iff (!rstN)
        (inValid && unit == FpUnitClassifier) |-> $onehot(classMask));

endmodule

`default_nettype wire

// File: FpComparator.sv
`timescale 1ns/1ns
`default_nettype none

module FpComparator import FpTypes::*; (
    output logic [wordWidth-1:0] intResult,
    output logic [wordWidth-1:0] fpResult,
    output logic                 invalid,
    input  FpCmpCommand          command,
    input  logic [wordWidth-1:0] fpSrc1,
    input  logic [wordWidth-1:0] fpSrc2
);

    // ##################################################
    // Operand decode.
    // ##################################################

    function automatic logic isNan(input logic [wordWidth-1:0] value);
        logic [expWidth-1:0]  exponent;
        logic [fracWidth-1:0] fraction;
        exponent = value[wordWidth-2 -: expWidth];
        fraction = value[fracWidth-1:0];
        return (&exponent) && (fraction != '0);
    endfunction

    function automatic logic isSignalingNan(input logic [wordWidth-1:0] value);
        return isNan(value) && !value[fracWidth-1];  // quiet bit is the fraction msb.
    endfunction

    logic nan1;
    logic nan2;
    logic anyNan;
    logic anySnan;
    logic bothZero;

    assign nan1     = isNan(fpSrc1);
    assign nan2     = isNan(fpSrc2);
    assign anyNan   = nan1 || nan2;
    assign anySnan  = isSignalingNan(fpSrc1) || isSignalingNan(fpSrc2);
    assign bothZero = (fpSrc1[wordWidth-2:0] == '0) && (fpSrc2[wordWidth-2:0] == '0);

    // ##################################################
    // Ordering.
    // ##################################################

    logic orderLt;  // sign-magnitude order where minus zero is below plus zero.
    logic lessThan;
    logic equal;

    always_comb begin
        if (fpSrc1[wordWidth-1] != fpSrc2[wordWidth-1]) begin
            orderLt = fpSrc1[wordWidth-1];  // the negative operand is the smaller one.
        end else if (fpSrc1[wordWidth-1]) begin
            orderLt = fpSrc1[wordWidth-2:0] > fpSrc2[wordWidth-2:0];
        end else begin
            orderLt = fpSrc1[wordWidth-2:0] < fpSrc2[wordWidth-2:0];
        end
    end

    assign lessThan = orderLt && !bothZero;  // the two zeros compare equal here.
    assign equal    = (fpSrc1 == fpSrc2) || bothZero;

    // ##################################################
    // Result selection.
    // ##################################################

    logic [wordWidth-1:0] minMax;

    always_comb begin
        if (nan1 && nan2) begin
            minMax = canonicalNan;
        end else if (nan1) begin
            minMax = fpSrc2;  // a single nan loses to the number.
        end else if (nan2) begin
            minMax = fpSrc1;
        end else if (command == FpCmpMin) begin
            minMax = orderLt ? fpSrc1 : fpSrc2;
        end else begin
            minMax = orderLt ? fpSrc2 : fpSrc1;
        end
    end

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        invalid   = anySnan;  // feq, fmin and fmax only trap on signaling nans.
        case (command)
            FpCmpEq: begin
                intResult[0] = equal && !anyNan;
            end
            FpCmpLt: begin
                intResult[0] = lessThan && !anyNan;
                invalid      = anyNan;
            end
            FpCmpLe: begin
                intResult[0] = (lessThan || equal) && !anyNan;
                invalid      = anyNan;
            end
            FpCmpMin, FpCmpMax: begin
                fpResult = minMax;
            end
            default: begin
                invalid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: FpFlagRegister.sv
`timescale 1ns/1ns
`default_nettype none

module FpFlagRegister (
    input  logic clk,
    input  logic rstN,
    input  logic nvPulse,
    input  logic clearFlags,
    output logic flagNv
);

    // ##################################################
    // Sticky invalid-operation flag.
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flagNv <= 1'b0;
        end else if (nvPulse) begin
            flagNv <= 1'b1;  // a new exception beats a clear in the same cycle.
        end else if (clearFlags) begin
            flagNv <= 1'b0;
        end
    end

    // The flag only comes up as the result of a reported exception.
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(flagNv) |-> $past(nvPulse));

endmodule

`default_nettype wire

// File: FpSignUnit.sv
`timescale 1ns/1ns
`default_nettype none

module FpSignUnit import FpTypes::*; (
    output logic [wordWidth-1:0] fpResult,
    input  FpSignCommand         command,
    input  logic [wordWidth-1:0] fpSrc1,
    input  logic [wordWidth-1:0] fpSrc2
);

    logic sign1;    // sign of the value whose magnitude is kept.
    logic sign2;
    logic signOut;

    assign sign1 = fpSrc1[wordWidth-1];
    assign sign2 = fpSrc2[wordWidth-1];

    always_comb begin
        case (command)
            FpSignJ: begin
                signOut = sign2;
            end
            FpSignJn: begin
                signOut = ~sign2;
            end
            FpSignJx: begin
                signOut = sign1 ^ sign2;
            end
            default: begin
                signOut = sign1;  // unused encoding leaves the operand as it is.
            end
        endcase
    end

    // Exponent and fraction pass through untouched, even for a nan.
    assign fpResult = {signOut, fpSrc1[wordWidth-2:0]};

endmodule

`default_nettype wire

// File: FpTypes.sv
`default_nettype none

package FpTypes;

    // ##################################################
    // Field widths of a single-precision word.
    // ##################################################

    localparam int wordWidth = 32;  // datapath width of both register files.
    localparam int expWidth  = 8;   // biased exponent field.
    localparam int fracWidth = 23;  // stored fraction, the hidden bit is not kept.

    // ##################################################
    // Operation selectors.
    // ##################################################

    // sub-unit that produces the result of an issued operation.
    typedef enum logic [1:0] {
        FpUnitMove,
        FpUnitClassifier,
        FpUnitSign,
        FpUnitComparator
    } FpUnitType;

    // sign injection flavours.
    typedef enum logic [1:0] {
        FpSignJ,   // take the sign of the second source.
        FpSignJn,  // take the inverted sign of the second source.
        FpSignJx   // xor of both signs.
    } FpSignCommand;

    typedef enum logic [2:0] {
        FpCmpEq,
        FpCmpLt,
        FpCmpLe,
        FpCmpMin,
        FpCmpMax
    } FpCmpCommand;

    // ##################################################
    // FCLASS result masks and special values.
    // ##################################################

    // One-hot masks, bit 0 is negative infinity as the ISA defines it.
    localparam logic [wordWidth-1:0] fpClassNegInf       = 32'h0000_0001;
    localparam logic [wordWidth-1:0] fpClassNegNormal    = 32'h0000_0002;
    localparam logic [wordWidth-1:0] fpClassNegSubnormal = 32'h0000_0004;
    localparam logic [wordWidth-1:0] fpClassNegZero      = 32'h0000_0008;
    localparam logic [wordWidth-1:0] fpClassPosZero      = 32'h0000_0010;
    localparam logic [wordWidth-1:0] fpClassPosSubnormal = 32'h0000_0020;
    localparam logic [wordWidth-1:0] fpClassPosNormal    = 32'h0000_0040;
    localparam logic [wordWidth-1:0] fpClassPosInf       = 32'h0000_0080;
    localparam logic [wordWidth-1:0] fpClassSignalingNan = 32'h0000_0100;
    localparam logic [wordWidth-1:0] fpClassQuietNan     = 32'h0000_0200;

    // positive quiet nan with an empty payload.
    localparam logic [wordWidth-1:0] canonicalNan = 32'h7fc0_0000;

endpackage

`default_nettype wire

// File: FpuChecker.sv
`timescale 1ns/1ns
`default_nettype none

module FpuChecker import FpTypes::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic                 clearFlags,
    input  logic [wordWidth-1:0] expInt,
    input  logic [wordWidth-1:0] expFp,
    input  logic                 expNv,
    input  logic                 outValid,
    input  logic [wordWidth-1:0] intResult,
    input  logic [wordWidth-1:0] fpResult,
    input  logic                 flagNv,
    input  int                   caseTotal,
    output int                   doneCount,
    output int                   failCount,
    output int                   strayCount
);

    logic [wordWidth-1:0] expIntQ[$];  // expected results of the cases in flight.
    logic [wordWidth-1:0] expFpQ[$];
    logic                 badQ[$];     // result verdicts waiting for their flag check.
    logic                 issueD1;
    logic                 issueD2;     // an issue two edges back, its flag is due now.
    logic                 nvStage;     // expected nv lined up with nvPulse.
    logic                 modelNv;     // reference copy of the sticky flag.

    always @(posedge clk) begin
        logic [wordWidth-1:0] wantInt;
        logic [wordWidth-1:0] wantFp;
        logic                 bad;
        if (!rstN) begin
            expIntQ.delete();
            expFpQ.delete();
            badQ.delete();
            issueD1    <= 1'b0;
            issueD2    <= 1'b0;
            nvStage    <= 1'b0;
            modelNv    <= 1'b0;
            doneCount  = 0;
            failCount  = 0;
            strayCount = 0;
        end else begin
            // ##################################################
            // flag check, the last step of a case.
            if (issueD2) begin
                if (badQ.size() == 0) begin
                    $display("case %0d: no result came out for this case", doneCount);
                    bad = 1'b1;
                end else begin
                    bad = badQ.pop_front();
                end
                if (flagNv !== modelNv) begin
                    $display("ERR flagNv case %0d: got 0x%0h expected 0x%0h",
                             doneCount, flagNv, modelNv);
                    bad = 1'b1;
                end
                if (bad) begin
                    $display("case %0d: failed", doneCount);
                    failCount = failCount + 1;
                end else begin
                    $display("case %0d: ok", doneCount);
                end
                doneCount = doneCount + 1;
                if (doneCount == caseTotal) begin
                    $display("checked %0d cases: %0d passed, %0d failed, %0d unexpected results",
                             doneCount, doneCount - failCount, failCount, strayCount);
                end
            end
            // ##################################################
            // result check, the queue keeps issue order.
            if (outValid) begin
                if (expIntQ.size() == 0) begin
                    $display("unexpected result: outValid came with no case in flight");
                    strayCount = strayCount + 1;
                end else begin
                    wantInt = expIntQ.pop_front();
                    wantFp  = expFpQ.pop_front();
                    bad     = 1'b0;
                    if (intResult !== wantInt) begin
                        $display("ERR intResult case %0d: got 0x%08h expected 0x%08h",
                                 doneCount + badQ.size(), intResult, wantInt);
                        bad = 1'b1;
                    end
                    if (fpResult !== wantFp) begin
                        $display("ERR fpResult case %0d: got 0x%08h expected 0x%08h",
                                 doneCount + badQ.size(), fpResult, wantFp);
                        bad = 1'b1;
                    end
                    badQ.push_back(bad);
                end
            end
            if (inValid) begin
                expIntQ.push_back(expInt);
                expFpQ.push_back(expFp);
            end
            modelNv <= nvStage ? 1'b1 : (clearFlags ? 1'b0 : modelNv);  // a set beats a clear.
            nvStage <= inValid && expNv;
            issueD1 <= inValid;
            issueD2 <= issueD1;
        end
    end

endmodule

`default_nettype wire

// File: FpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module FpuTb import FpTypes::*; ();

    localparam int maxCases    = 64;
    localparam int resetCycles = 8;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 inValid;
    logic                 clearFlags;
    FpUnitType            unit;
    FpSignCommand         signCmd;
    FpCmpCommand          cmpCmd;
    logic [wordWidth-1:0] intSrc1;
    logic [wordWidth-1:0] fpSrc1;
    logic [wordWidth-1:0] fpSrc2;
    logic                 outValid;
    logic [wordWidth-1:0] intResult;
    logic [wordWidth-1:0] fpResult;
    logic                 flagNv;
    logic [wordWidth-1:0] expInt;   // expected values travel next to the stimulus.
    logic [wordWidth-1:0] expFp;
    logic                 expNv;
    int                   doneCount;
    int                   failCount;
    int                   strayCount;
    int                   numCases;
    int                   cycleCount = 0;
    int                   cycleLimit = 0;

    // one entry per line of the cases file.
    logic [wordWidth-1:0] caseClear  [maxCases];
    logic [wordWidth-1:0] caseUnit   [maxCases];
    logic [wordWidth-1:0] caseSign   [maxCases];
    logic [wordWidth-1:0] caseCmp    [maxCases];
    logic [wordWidth-1:0] caseInt    [maxCases];
    logic [wordWidth-1:0] caseFp1    [maxCases];
    logic [wordWidth-1:0] caseFp2    [maxCases];
    logic [wordWidth-1:0] caseExpInt [maxCases];
    logic [wordWidth-1:0] caseExpFp  [maxCases];
    logic [wordWidth-1:0] caseExpNv  [maxCases];

    always #5 clk = ~clk;

    FpuTop UUT (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .unit(unit),
        .signCmd(signCmd),
        .cmpCmd(cmpCmd),
        .intSrc1(intSrc1),
        .fpSrc1(fpSrc1),
        .fpSrc2(fpSrc2),
        .clearFlags(clearFlags),
        .outValid(outValid),
        .intResult(intResult),
        .fpResult(fpResult),
        .flagNv(flagNv)
    );

    FpuChecker resultChecker (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .clearFlags(clearFlags),
        .expInt(expInt),
        .expFp(expFp),
        .expNv(expNv),
        .outValid(outValid),
        .intResult(intResult),
        .fpResult(fpResult),
        .flagNv(flagNv),
        .caseTotal(numCases),
        .doneCount(doneCount),
        .failCount(failCount),
        .strayCount(strayCount)
    );

    // ##################################################
    // Case file and stimulus.
    // ##################################################

    task automatic readCases();
        int               fd;
        int               count;
        logic [8*256-1:0] skipped;
        fd = $fopen("fpuCases.txt", "r");
        if (fd == 0) begin
            $display("could not open fpuCases.txt");
        end else begin
            while (!$feof(fd) && numCases < maxCases) begin
                count = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h\n",
                                caseClear[numCases], caseUnit[numCases], caseSign[numCases],
                                caseCmp[numCases], caseInt[numCases], caseFp1[numCases],
                                caseFp2[numCases], caseExpInt[numCases], caseExpFp[numCases],
                                caseExpNv[numCases]);
                if (count == 10) begin
                    numCases = numCases + 1;
                end else begin
                    void'($fgets(skipped, fd));  // comment line.
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runCase(input int idx);
        int unsigned gap;
        if (caseClear[idx][0]) begin
            @(posedge clk);
            #1;
            inValid    = 1'b0;
            clearFlags = 1'b1;  // one clear cycle ahead of the issue.
        end
        @(posedge clk);
        #1;
        clearFlags = 1'b0;
        inValid    = 1'b1;
        unit       = FpUnitType'(caseUnit[idx][1:0]);
        signCmd    = FpSignCommand'(caseSign[idx][1:0]);
        cmpCmd     = FpCmpCommand'(caseCmp[idx][2:0]);
        intSrc1    = caseInt[idx];
        fpSrc1     = caseFp1[idx];
        fpSrc2     = caseFp2[idx];
        expInt     = caseExpInt[idx];
        expFp      = caseExpFp[idx];
        expNv      = caseExpNv[idx][0];
        gap = 0;
        if ($urandom % 4 == 0) begin
            gap = 1 + $urandom % 3;  // most cases go back to back.
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    // ##################################################
    // Main sequence and watchdog.
    // ##################################################

    initial begin
        rstN       = 1'b0;
        inValid    = 1'b0;
        clearFlags = 1'b0;
        unit       = FpUnitMove;
        signCmd    = FpSignJ;
        cmpCmd     = FpCmpEq;
        intSrc1    = '0;
        fpSrc1     = '0;
        fpSrc2     = '0;
        expInt     = '0;
        expFp      = '0;
        expNv      = 1'b0;
        void'($urandom(32'h6f9b_f56f));
        numCases   = 0;
        readCases();
        cycleLimit = resetCycles + 6 * numCases + 50;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int i = 0; i < numCases; i++) begin
            runCase(i);
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
        wait (doneCount == numCases);
        repeat (2) @(posedge clk);  // room for a stray result to show up.
        if (numCases > 0 && failCount == 0 && strayCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout: run stopped after %0d cycles, %0d of %0d cases done",
                     cycleCount, doneCount, numCases);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: FpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module FpuTop import FpTypes::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  FpUnitType            unit,
    input  FpSignCommand         signCmd,
    input  FpCmpCommand          cmpCmd,
    input  logic [wordWidth-1:0] intSrc1,
    input  logic [wordWidth-1:0] fpSrc1,
    input  logic [wordWidth-1:0] fpSrc2,
    input  logic                 clearFlags,
    output logic                 outValid,
    output logic [wordWidth-1:0] intResult,
    output logic [wordWidth-1:0] fpResult,
    output logic                 flagNv
);

    logic nvPulse;  // invalid report travelling with the registered result.

    Fp32Unit fpUnit (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .unit(unit),
        .signCmd(signCmd),
        .cmpCmd(cmpCmd),
        .intSrc1(intSrc1),
        .fpSrc1(fpSrc1),
        .fpSrc2(fpSrc2),
        .outValid(outValid),
        .intResult(intResult),
        .fpResult(fpResult),
        .nvPulse(nvPulse)
    );

    FpFlagRegister flagRegister (
        .clk(clk),
        .rstN(rstN),
        .nvPulse(nvPulse),
        .clearFlags(clearFlags),
        .flagNv(flagNv)
    );

endmodule

`default_nettype wire

// File: fpuCases.txt
# clr unit sgn cmp intSrc1 fpSrc1 fpSrc2 expInt expFp nv  (all hex)
# unit 0 move 1 class 2 sign 3 cmp; sgn 0 j 1 jn 2 jx; cmp 0 eq 1 lt 2 le 3 min 4 max
0 0 0 0 12345678 3f800000 00000000 3f800000 12345678 0
0 0 0 0 deadbeef 7fa00001 00000000 7fa00001 deadbeef 0
0 1 0 0 00000000 ff800000 00000000 00000001 00000000 0
0 1 0 0 00000000 bf800000 00000000 00000002 00000000 0
0 1 0 0 00000000 80000001 00000000 00000004 00000000 0
0 1 0 0 00000000 80000000 00000000 00000008 00000000 0
0 1 0 0 00000000 00000000 00000000 00000010 00000000 0
0 1 0 0 00000000 007fffff 00000000 00000020 00000000 0
0 1 0 0 00000000 3f800000 00000000 00000040 00000000 0
0 1 0 0 00000000 7f800000 00000000 00000080 00000000 0
0 1 0 0 00000000 7f800001 00000000 00000100 00000000 0
0 1 0 0 00000000 7fc00000 00000000 00000200 00000000 0
0 2 0 0 00000000 3f800000 bf800000 00000000 bf800000 0
0 2 1 0 00000000 3f800000 bf800000 00000000 3f800000 0
0 2 1 0 00000000 3f800000 3f800000 00000000 bf800000 0
0 2 2 0 00000000 bf800000 bf800000 00000000 3f800000 0
0 2 2 0 00000000 c0490fdb 00000000 00000000 c0490fdb 0
0 2 0 0 00000000 7fc00000 80000000 00000000 ffc00000 0
0 2 0 0 00000000 80000000 00000000 00000000 00000000 0
1 3 0 0 00000000 00000000 80000000 00000001 00000000 0
0 3 0 0 00000000 3f800000 40000000 00000000 00000000 0
0 3 0 0 00000000 7fc00000 7fc00000 00000000 00000000 0
0 3 0 0 00000000 7f800001 3f800000 00000000 00000000 1
0 3 0 1 00000000 bf800000 3f800000 00000001 00000000 0
0 3 0 1 00000000 80000000 00000000 00000000 00000000 0
0 3 0 1 00000000 c0000000 bf800000 00000001 00000000 0
1 3 0 1 00000000 7fc00000 3f800000 00000000 00000000 1
1 3 0 2 00000000 00000000 80000000 00000001 00000000 0
0 3 0 2 00000000 40000000 3f800000 00000000 00000000 0
0 3 0 2 00000000 3f800000 7fc00000 00000000 00000000 1
1 3 0 3 00000000 80000000 00000000 00000000 80000000 0
1 3 0 4 00000000 80000000 00000000 00000000 00000000 0
0 3 0 3 00000000 00000000 80000000 00000000 80000000 0
0 3 0 4 00000000 3f800000 c0000000 00000000 3f800000 0
0 3 0 3 00000000 7fc00000 40000000 00000000 40000000 0
0 3 0 4 00000000 40000000 7f800001 00000000 40000000 1
1 3 0 3 00000000 7fc00000 ffc00001 00000000 7fc00000 0
0 3 0 4 00000000 7f800001 7fc00000 00000000 7fc00000 1

// File: run.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module FpuTb -f tb.f > sim.log 2>&1 &&
./obj_dir/VFpuTb >> sim.log 2>&1 ||
echo "build or simulation stopped early, RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: tb.f
FpTypes.sv
FpSignUnit.sv
FpComparator.sv
Fp32Unit.sv
FpFlagRegister.sv
FpuTop.sv
FpuChecker.sv
FpuTb.sv
